/* src/ohci_pkg.sv */
// OHCI list processing shared definitions
// Frame timing, register map, list types and the descriptor and port bundles
package ohci_pkg;

  // Frame timing, shortened for simulation (hardware uses 12000 cycles)
  localparam int unsigned FrameLen      = 96;
  localparam int unsigned PeriodicStart = 64;  // First cycle of the periodic window
  localparam int unsigned FrameCntWidth = $clog2(FrameLen);

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned EdWords       = 4;   // Words per endpoint descriptor
  localparam int unsigned EdCntWidth    = $clog2(EdWords);
  localparam int unsigned RegAddrWidth  = 4;   // Word offsets
  localparam int unsigned CountWidth    = 16;  // Frame number and served counter
  localparam int unsigned FaWidth       = 7;   // USB function address
  localparam int unsigned EnWidth       = 4;   // USB endpoint number

  // Register map, word offsets
  localparam logic [RegAddrWidth-1:0] RegControl  = 4'd0;  // run [0], ratio [2:1]
  localparam logic [RegAddrWidth-1:0] RegStatus   = 4'd1;  // sof flag [0], write 1 clears
  localparam logic [RegAddrWidth-1:0] RegIntEn    = 4'd2;
  localparam logic [RegAddrWidth-1:0] RegPerHead  = 4'd3;
  localparam logic [RegAddrWidth-1:0] RegCtrlHead = 4'd4;
  localparam logic [RegAddrWidth-1:0] RegBulkHead = 4'd5;
  localparam logic [RegAddrWidth-1:0] RegCtrlCur  = 4'd6;
  localparam logic [RegAddrWidth-1:0] RegBulkCur  = 4'd7;
  localparam logic [RegAddrWidth-1:0] RegFrameNum = 4'd8;
  localparam logic [RegAddrWidth-1:0] RegServed   = 4'd9;

  typedef enum logic [1:0] {
    PERIODIC = 2'b00,
    CONTROL  = 2'b01,
    BULK     = 2'b10
  } channel_e;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    FETCH   = 2'b01,
    WAIT_ED = 2'b10
  } ls_state_e;

  typedef struct packed {
    logic                    we;
    logic                    re;
    logic [RegAddrWidth-1:0] addr;
    logic [DataWidth-1:0]    wdata;
  } reg_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] addr;
  } dma_req_t;

  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] data;
  } dma_rsp_t;

  typedef struct packed {
    logic                 skip;  // K bit, ED is passed over
    logic [FaWidth-1:0]   fa;
    logic [EnWidth-1:0]   en;
    logic [AddrWidth-1:0] tail;  // TD queue tail
    logic [AddrWidth-1:0] head;  // TD queue head
    logic [AddrWidth-1:0] next;  // Next ED, zero ends the list
  } ed_t;

  typedef struct packed {
    logic                 run;
    logic [1:0]           ratio;  // ratio+1 control EDs per bulk ED
    logic [AddrWidth-1:0] per_head;
    logic [AddrWidth-1:0] ctrl_head;
    logic [AddrWidth-1:0] bulk_head;
  } list_cfg_t;

endpackage

/* src/ohci_regs.sv */
// OHCI operational registers
// Software read/write port, list heads and currents, frame number and sof interrupt
`timescale 1ns/1ns

module ohci_regs (
  input  logic                           rst_n_i,
  input  logic                           soc_clk_i,
  input  ohci_pkg::reg_req_t             reg_req_i,
  output ohci_pkg::reg_rsp_t             reg_rsp_o,
  output ohci_pkg::list_cfg_t            cfg_o,
  output logic [ohci_pkg::AddrWidth-1:0] ctrl_cur_o,  // Current control ED
  output logic [ohci_pkg::AddrWidth-1:0] bulk_cur_o,  // Current bulk ED
  input  logic                           cur_upd_i,
  input  ohci_pkg::channel_e             cur_chan_i,
  input  logic [ohci_pkg::AddrWidth-1:0] cur_ptr_i,
  input  logic                           served_i,
  input  logic                           sof_i,
  output logic                           intr_o
);
  import ohci_pkg::*;

  logic                  run_q;
  logic [1:0]            ratio_q;
  logic                  sof_flag_q;
  logic                  int_en_q;
  logic [AddrWidth-1:0]  per_head_q, ctrl_head_q, bulk_head_q;
  logic [AddrWidth-1:0]  ctrl_cur_q, bulk_cur_q;
  logic [CountWidth-1:0] frame_num_q, served_q;
  logic                  rvalid_q;
  logic [DataWidth-1:0]  rdata_q, rdata_d;
  logic                  wr;

  assign wr = reg_req_i.we;

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q       <= 1'b0;
      ratio_q     <= '0;
      sof_flag_q  <= 1'b0;
      int_en_q    <= 1'b0;
      per_head_q  <= '0;
      ctrl_head_q <= '0;
      bulk_head_q <= '0;
      ctrl_cur_q  <= '0;
      bulk_cur_q  <= '0;
      frame_num_q <= '0;
      served_q    <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= reg_req_i.re;  // Answer exactly one cycle later
      if (wr && reg_req_i.addr == RegControl) begin
        run_q   <= reg_req_i.wdata[0];
        ratio_q <= reg_req_i.wdata[2:1];
      end
      if (wr && reg_req_i.addr == RegIntEn) int_en_q <= reg_req_i.wdata[0];
      if (wr && reg_req_i.addr == RegPerHead) per_head_q <= reg_req_i.wdata;
      if (wr && reg_req_i.addr == RegCtrlHead) ctrl_head_q <= reg_req_i.wdata;
      if (wr && reg_req_i.addr == RegBulkHead) bulk_head_q <= reg_req_i.wdata;
      // Hardware walk first, software write overrides it
      if (cur_upd_i && cur_chan_i == CONTROL) ctrl_cur_q <= cur_ptr_i;
      if (cur_upd_i && cur_chan_i == BULK) bulk_cur_q <= cur_ptr_i;
      if (wr && (reg_req_i.addr == RegCtrlHead || reg_req_i.addr == RegCtrlCur)) begin
        ctrl_cur_q <= reg_req_i.wdata;  // New head restarts the list
      end
      if (wr && (reg_req_i.addr == RegBulkHead || reg_req_i.addr == RegBulkCur)) begin
        bulk_cur_q <= reg_req_i.wdata;
      end
      // Set beats a same-cycle write-1 clear
      if (sof_i) sof_flag_q <= 1'b1;
      else if (wr && reg_req_i.addr == RegStatus && reg_req_i.wdata[0]) sof_flag_q <= 1'b0;
      if (sof_i) frame_num_q <= frame_num_q + 1'b1;
      if (served_i) served_q <= served_q + 1'b1;
    end
  end

  always_comb begin
    unique case (reg_req_i.addr)
      RegControl:  rdata_d = DataWidth'({ratio_q, run_q});
      RegStatus:   rdata_d = DataWidth'(sof_flag_q);
      RegIntEn:    rdata_d = DataWidth'(int_en_q);
      RegPerHead:  rdata_d = per_head_q;
      RegCtrlHead: rdata_d = ctrl_head_q;
      RegBulkHead: rdata_d = bulk_head_q;
      RegCtrlCur:  rdata_d = ctrl_cur_q;
      RegBulkCur:  rdata_d = bulk_cur_q;
      RegFrameNum: rdata_d = DataWidth'(frame_num_q);
      RegServed:   rdata_d = DataWidth'(served_q);
      default:     rdata_d = '0;  // Unmapped offsets read zero
    endcase
  end

  always_ff @(posedge soc_clk_i) begin
    if (reg_req_i.re) rdata_q <= rdata_d;
  end

  assign reg_rsp_o.rvalid = rvalid_q;
  assign reg_rsp_o.rdata  = rdata_q;

  assign cfg_o.run       = run_q;
  assign cfg_o.ratio     = ratio_q;
  assign cfg_o.per_head  = per_head_q;
  assign cfg_o.ctrl_head = ctrl_head_q;
  assign cfg_o.bulk_head = bulk_head_q;
  assign ctrl_cur_o      = ctrl_cur_q;
  assign bulk_cur_o      = bulk_cur_q;

  assign intr_o = sof_flag_q & int_en_q;  // Level until software clears the flag

endmodule

/* src/ohci_frame_timer.sv */
// OHCI frame timer
// Splits each frame into a nonperiodic then a periodic window, with switch pulses
`timescale 1ns/1ns

module ohci_frame_timer (
  input  logic soc_clk_i,
  input  logic rst_n_i,
  input  logic run_i,       // Controller operational
  output logic periodic_o,  // High during periodic window
  output logic np2p_o,      // One cycle at window rise
  output logic p2np_o,      // One cycle at window fall
  output logic sof_o        // Start of frame
);
  import ohci_pkg::*;

  logic [FrameCntWidth-1:0] cnt_q;
  logic                     periodic_prev_q;
  logic                     frame_end;

  assign frame_end = (cnt_q == FrameCntWidth'(FrameLen - 1));

  // Held at zero while stopped, so a new run starts a fresh frame
  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!run_i) begin
      cnt_q <= '0;
    end else if (frame_end) begin
      cnt_q <= '0;  // Wrap
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign sof_o      = run_i && (cnt_q == '0);
  assign periodic_o = run_i && (cnt_q >= FrameCntWidth'(PeriodicStart));

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      periodic_prev_q <= 1'b0;
    end else begin
      periodic_prev_q <= periodic_o;
    end
  end

  // Edge detect on the window level
  assign np2p_o = periodic_o && !periodic_prev_q;
  assign p2np_o = !periodic_o && periodic_prev_q;  // Lands on sof at wrap

endmodule

/* src/ohci_list_service.sv */
// OHCI list service
// Picks the next ED from the periodic, control or bulk list and follows next pointers
`timescale 1ns/1ns

module ohci_list_service (
  input  logic                           soc_clk_i,
  input  logic                           rst_n_i,
  input  ohci_pkg::list_cfg_t            cfg_i,
  input  logic [ohci_pkg::AddrWidth-1:0] ctrl_cur_i,
  input  logic [ohci_pkg::AddrWidth-1:0] bulk_cur_i,
  input  logic                           periodic_i,
  input  logic                           np2p_i,
  input  logic                           p2np_i,
  output logic                           fetch_o,
  output logic [ohci_pkg::AddrWidth-1:0] fetch_addr_o,
  input  logic                           ed_valid_i,
  input  ohci_pkg::ed_t                  ed_i,
  output logic                           cur_upd_o,
  output ohci_pkg::channel_e             cur_chan_o,
  output logic [ohci_pkg::AddrWidth-1:0] cur_ptr_o,
  output logic                           served_o
);
  import ohci_pkg::*;

  ls_state_e            state_q, state_d;
  channel_e             chan_q;      // List of the ED in flight
  channel_e             pick_chan;
  logic [AddrWidth-1:0] per_ptr_q;   // Local periodic walk pointer
  logic                 per_done_q;  // Periodic list finished for this frame
  logic [2:0]           ctrl_cnt_q;  // Control EDs since last bulk
  logic [2:0]           ctrl_cnt;
  logic                 ctrl_ok, bulk_ok;
  logic                 pick_per, pick_ctrl, pick_bulk, pick_any;
  logic                 ed_done;

  assign ctrl_cnt = p2np_i ? 3'd0 : ctrl_cnt_q;  // Each nonperiodic window starts fresh

  // Empty lists are skipped
  assign ctrl_ok   = cfg_i.run && !periodic_i && (ctrl_cur_i != '0);
  assign bulk_ok   = cfg_i.run && !periodic_i && (bulk_cur_i != '0);
  assign pick_per  = cfg_i.run && periodic_i && !per_done_q && (per_ptr_q != '0);
  assign pick_ctrl = ctrl_ok && ((ctrl_cnt <= {1'b0, cfg_i.ratio}) || !bulk_ok);
  assign pick_bulk = bulk_ok && !pick_ctrl;
  assign pick_any  = pick_per || pick_ctrl || pick_bulk;

  always_comb begin
    pick_chan    = BULK;
    fetch_addr_o = bulk_cur_i;
    if (pick_per) begin
      pick_chan    = PERIODIC;
      fetch_addr_o = per_ptr_q;
    end else if (pick_ctrl) begin
      pick_chan    = CONTROL;
      fetch_addr_o = ctrl_cur_i;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (pick_any) state_d = FETCH;
      FETCH:   state_d = pick_any ? WAIT_ED : IDLE;
      WAIT_ED: if (ed_valid_i) state_d = FETCH;  // Finish in-flight ED first
      default: state_d = IDLE;
    endcase
  end

  assign fetch_o = (state_q == FETCH) && pick_any;
  assign ed_done = (state_q == WAIT_ED) && ed_valid_i;

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      chan_q     <= BULK;
      per_ptr_q  <= '0;
      per_done_q <= 1'b1;
      ctrl_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (fetch_o) chan_q <= pick_chan;
      if (fetch_o && pick_bulk) begin
        ctrl_cnt_q <= '0;
      end else if (fetch_o && pick_ctrl) begin
        // Control alone when bulk is empty restarts the count
        ctrl_cnt_q <= (ctrl_cnt > {1'b0, cfg_i.ratio}) ? 3'd1 : ctrl_cnt + 3'd1;
      end else if (p2np_i) begin
        ctrl_cnt_q <= '0;
      end
      if (ed_done && chan_q == PERIODIC) begin
        per_ptr_q <= ed_i.next;
        if (ed_i.next == '0) per_done_q <= 1'b1;  // End of periodic list
      end
      if (p2np_i) per_done_q <= 1'b1;  // Window closed, unfinished walk dropped
      if (np2p_i) begin
        per_ptr_q  <= cfg_i.per_head;  // Walk restarts from head every frame
        per_done_q <= 1'b0;
      end
    end
  end

  // Control and bulk currents live in the register block
  assign cur_upd_o  = ed_done && (chan_q != PERIODIC);
  assign cur_chan_o = chan_q;
  always_comb begin
    if (ed_i.next != '0) cur_ptr_o = ed_i.next;
    else if (chan_q == CONTROL) cur_ptr_o = cfg_i.ctrl_head;  // Wrap to head
    else cur_ptr_o = cfg_i.bulk_head;
  end

  assign served_o = ed_done && !ed_i.skip;

endmodule

/* src/ohci_ed_unpack.sv */
// OHCI endpoint descriptor fetch
// One memory read per fetch, four words collected and split into ED fields
`timescale 1ns/1ns

module ohci_ed_unpack (
  input  logic                           soc_clk_i,
  input  logic                           rst_n_i,
  input  logic                           fetch_i,
  input  logic [ohci_pkg::AddrWidth-1:0] fetch_addr_i,
  output ohci_pkg::dma_req_t             dma_req_o,
  input  ohci_pkg::dma_rsp_t             dma_rsp_i,
  output logic                           ed_valid_o,
  output ohci_pkg::ed_t                  ed_o
);
  import ohci_pkg::*;

  logic                  req_q;
  logic [AddrWidth-1:0]  addr_q;
  logic                  busy_q;   // Words still outstanding
  logic [EdCntWidth-1:0] cnt_q;    // Next word slot
  logic                  done_q;
  logic                  take;
  logic                  last_word;
  logic [DataWidth-1:0]  words_q [EdWords];

  assign take      = busy_q && dma_rsp_i.valid;  // Stray responses ignored
  assign last_word = take && (cnt_q == EdCntWidth'(EdWords - 1));

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      busy_q <= 1'b0;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      req_q  <= fetch_i;  // Single-cycle request
      done_q <= last_word;
      if (fetch_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (take) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_word) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (fetch_i) addr_q <= fetch_addr_i;
    if (take) words_q[cnt_q] <= dma_rsp_i.data;  // Words arrive in address order
  end

  assign dma_req_o.req  = req_q;
  assign dma_req_o.addr = addr_q;

  assign ed_valid_o = done_q;

  // Word 0 carries endpoint control
  assign ed_o.fa   = words_q[0][FaWidth-1:0];
  assign ed_o.en   = words_q[0][FaWidth+EnWidth-1:FaWidth];
  assign ed_o.skip = words_q[0][14];

  // Pointers are 16-byte aligned, low bits masked
  assign ed_o.tail = {words_q[1][AddrWidth-1:4], 4'b0000};
  assign ed_o.head = {words_q[2][AddrWidth-1:4], 4'b0000};  // Drops halted/carry
  assign ed_o.next = {words_q[3][AddrWidth-1:4], 4'b0000};

endmodule

/* src/ohci_host.sv */
// OHCI host controller list processing top level
// Register block, frame timer, list service and ED fetch on the SoC clock
`timescale 1ns/1ns

module ohci_host (
  input  logic               soc_clk_i,
  input  logic               rst_n_i,
  input  ohci_pkg::reg_req_t reg_req_i,  // Software port
  output ohci_pkg::reg_rsp_t reg_rsp_o,
  output ohci_pkg::dma_req_t dma_req_o,  // Memory read port
  input  ohci_pkg::dma_rsp_t dma_rsp_i,
  output logic               intr_o
);
  import ohci_pkg::*;

  list_cfg_t            cfg;
  logic [AddrWidth-1:0] ctrl_cur, bulk_cur;
  logic                 cur_upd;
  channel_e             cur_chan;
  logic [AddrWidth-1:0] cur_ptr;
  logic                 served;
  logic                 sof;
  logic                 periodic, np2p, p2np;  // Frame window and its edges
  logic                 fetch;
  logic [AddrWidth-1:0] fetch_addr;
  logic                 ed_valid;
  ed_t                  ed;

  ohci_regs u_regs (
    .rst_n_i    ( rst_n_i   ),
    .soc_clk_i  ( soc_clk_i ),
    .reg_req_i  ( reg_req_i ),
    .reg_rsp_o  ( reg_rsp_o ),
    .cfg_o      ( cfg       ),
    .ctrl_cur_o ( ctrl_cur  ),
    .bulk_cur_o ( bulk_cur  ),
    .cur_upd_i  ( cur_upd   ),
    .cur_chan_i ( cur_chan  ),
    .cur_ptr_i  ( cur_ptr   ),
    .served_i   ( served    ),
    .sof_i      ( sof       ),
    .intr_o     ( intr_o    )
  );

  ohci_frame_timer u_frame_timer (
    .soc_clk_i  ( soc_clk_i ),
    .rst_n_i    ( rst_n_i   ),
    .run_i      ( cfg.run   ),
    .periodic_o ( periodic  ),
    .np2p_o     ( np2p      ),
    .p2np_o     ( p2np      ),
    .sof_o      ( sof       )
  );

  ohci_list_service u_list_service (
    .soc_clk_i    ( soc_clk_i  ),
    .rst_n_i      ( rst_n_i    ),
    .cfg_i        ( cfg        ),
    .ctrl_cur_i   ( ctrl_cur   ),
    .bulk_cur_i   ( bulk_cur   ),
    .periodic_i   ( periodic   ),
    .np2p_i       ( np2p       ),
    .p2np_i       ( p2np       ),
    .fetch_o      ( fetch      ),
    .fetch_addr_o ( fetch_addr ),
    .ed_valid_i   ( ed_valid   ),
    .ed_i         ( ed         ),
    .cur_upd_o    ( cur_upd    ),
    .cur_chan_o   ( cur_chan   ),
    .cur_ptr_o    ( cur_ptr    ),
    .served_o     ( served     )
  );

  ohci_ed_unpack u_ed_unpack (
    .soc_clk_i    ( soc_clk_i  ),
    .rst_n_i      ( rst_n_i    ),
    .fetch_i      ( fetch      ),
    .fetch_addr_i ( fetch_addr ),
    .dma_req_o    ( dma_req_o  ),
    .dma_rsp_i    ( dma_rsp_i  ),
    .ed_valid_o   ( ed_valid   ),
    .ed_o         ( ed         )
  );

endmodule

/* sim/ohci_host_properties.sv */
// OHCI host interface checks
// Bound to the top level to watch the memory and register ports
`timescale 1ns/1ns

module ohci_host_properties (
  input logic               soc_clk_i,
  input logic               rst_n_i,
  input ohci_pkg::reg_req_t reg_req_i,
  input ohci_pkg::reg_rsp_t reg_rsp_o,
  input ohci_pkg::dma_req_t dma_req_o,
  input logic               intr_o
);
  import ohci_pkg::*;

  logic int_en_q;  // Mirror of the enable register

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) int_en_q <= 1'b0;
    else if (reg_req_i.we && reg_req_i.addr == RegIntEn) int_en_q <= reg_req_i.wdata[0];
  end

  req_one_cycle: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    dma_req_o.req |=> !dma_req_o.req) else $error("memory request longer than one cycle");

  // Enable reads also carry the mirrored value
  read_answered: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    reg_req_i.re |=> reg_rsp_o.rvalid &&
      ($past(reg_req_i.addr) != RegIntEn || reg_rsp_o.rdata == DataWidth'($past(int_en_q))))
    else $error("register read not answered or enable read back wrong");

  intr_masked: assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    !int_en_q |-> !intr_o) else $error("interrupt raised while disabled");

endmodule

bind ohci_host ohci_host_properties u_props (.*);

/* sim/ohci_host_tb.sv */
// OHCI host testbench
// Directed tests with an ED memory model and a request monitor
`timescale 1ns/1ns

module ohci_host_tb;
  import ohci_pkg::*;

  localparam logic [31:0] C1 = 32'h10, C2 = 32'h20, B1 = 32'h30;  // Control and bulk EDs
  localparam logic [31:0] P1 = 32'h40, P2 = 32'h50, P3 = 32'h60;  // Periodic EDs
  localparam int TimeoutCycles = 20 * FrameLen;

  logic clk, rst_n, intr;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  dma_req_t dma_req;
  dma_rsp_t dma_rsp;
  logic [31:0] mem [64];  // Word-indexed ED memory
  logic [7:0] lfsr = 8'd88;
  logic [31:0] req_addr [$];
  int req_cyc [$];
  int cyc = 0, req_total = 0, words_sent = 0, run_cyc;

  ohci_host u_ohci_host (.soc_clk_i(clk), .rst_n_i(rst_n), .reg_req_i(reg_req),
    .reg_rsp_o(reg_rsp), .dma_req_o(dma_req), .dma_rsp_i(dma_rsp), .intr_o(intr));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic next_rand_bit();  // x^8+x^6+x^5+x^4+1
    logic fb;
    fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    lfsr = {lfsr[6:0], fb};
    return fb;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Request monitor and cycle limit sampled mid-cycle
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (dma_req.req) begin
      req_addr.push_back(dma_req.addr);
      req_cyc.push_back(cyc);
      req_total = req_total + 1;
    end
    if (cyc > TimeoutCycles) begin
      $display("Timeout, the DUT stopped making progress");
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // Memory answers after 1 to 4 cycles, then four words back to back
  initial begin : mem_model
    logic [5:0] base;
    int delay;
    forever begin
      @(negedge clk);
      if (dma_req.req) begin
        base = dma_req.addr[7:2];
        delay = 1 + 2 * next_rand_bit();
        delay = delay + next_rand_bit();
        repeat (delay) @(posedge clk);
        for (int k = 0; k < EdWords; k++) begin
          dma_rsp <= {1'b1, mem[base + k]};
          words_sent = words_sent + 1;
          @(posedge clk);
        end
        dma_rsp <= '0;
      end
    end
  end

  task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
    @(posedge clk);
    reg_req <= '{we: 1'b1, re: 1'b0, addr: a, wdata: d};
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic reg_read(input logic [3:0] a, output logic [31:0] d);
    @(posedge clk);
    reg_req <= '{we: 1'b0, re: 1'b1, addr: a, wdata: 32'h0};
    @(posedge clk);
    reg_req <= '0;
    @(negedge clk);
    check("read valid", 1, reg_rsp.rvalid);
    d = reg_rsp.rdata;
  endtask

  task automatic put_ed(input logic [31:0] a, input logic skip, input logic [31:0] nxt);
    mem[a[7:2]]     = {17'h0, skip, 3'h0, 4'h1, a[10:4]};  // Skip bit 14, en and fa
    mem[a[7:2] + 1] = 32'h0;
    mem[a[7:2] + 2] = 32'h0;
    mem[a[7:2] + 3] = nxt;
  endtask

  task automatic start_run();  // Ratio 1, run set
    req_addr.delete();
    req_cyc.delete();
    reg_write(RegControl, 32'h3);
    run_cyc = cyc;
  endtask

  task automatic stop_and_settle();  // Wait until every fetched ED is complete
    reg_write(RegControl, 32'h0);
    repeat (2) @(negedge clk);
    while (words_sent != EdWords * req_total) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic test_registers();
    logic [31:0] d;
    reg_write(RegPerHead, P1);
    reg_write(RegCtrlHead, C1);
    reg_write(RegBulkHead, B1);
    reg_write(RegControl, 32'h4);  // Ratio 2, stopped
    reg_write(RegIntEn, 32'h1);
    reg_read(RegPerHead, d);
    check("registers per head", P1, d);
    reg_read(RegCtrlHead, d);
    check("registers ctrl head", C1, d);
    reg_read(RegBulkHead, d);
    check("registers bulk head", B1, d);
    reg_read(RegControl, d);
    check("registers control", 32'h4, d);
    reg_read(RegIntEn, d);
    check("registers enable", 32'h1, d);
    reg_read(RegCtrlCur, d);
    check("registers ctrl current", C1, d);
    reg_read(RegBulkCur, d);
    check("registers bulk current", B1, d);
    reg_write(RegIntEn, 32'h0);
    reg_write(RegPerHead, 32'h0);  // No periodic list yet
  endtask

  task automatic test_ratio();
    logic [31:0] cptr, bptr, exp;
    int n, seen;
    cptr = C1;
    bptr = B1;
    n = 0;
    seen = 0;
    start_run();
    while (cyc < run_cyc + FrameLen) @(negedge clk);
    foreach (req_addr[i]) begin
      if (req_cyc[i] - run_cyc < FrameLen) begin  // First frame only
        if (n <= 1) begin  // ratio+1 control EDs, then one bulk
          exp = cptr;
          cptr = (mem[cptr[7:2] + 3] != 0) ? mem[cptr[7:2] + 3] : C1;
          n = n + 1;
        end else begin
          exp = bptr;
          bptr = (mem[bptr[7:2] + 3] != 0) ? mem[bptr[7:2] + 3] : B1;
          n = 0;
        end
        check("ratio order", exp, req_addr[i]);
        seen = seen + 1;
      end
    end
    check("ratio bulk reached", 1, seen >= 3);
    stop_and_settle();
  endtask

  task automatic test_periodic_and_skip();
    logic [31:0] base, served;
    logic [31:0] per [3];
    int first, frame0, clear_cnt;
    per = '{P1, P2, P3};
    first = -1;
    frame0 = 0;
    clear_cnt = 0;
    reg_read(RegServed, base);
    reg_write(RegPerHead, P1);
    reg_write(RegCtrlHead, C1);
    reg_write(RegBulkHead, B1);
    start_run();
    while (cyc < run_cyc + FrameLen) @(negedge clk);
    stop_and_settle();
    foreach (req_addr[i]) begin
      if (req_cyc[i] - run_cyc < FrameLen) frame0 = frame0 + 1;
      if (first < 0 && req_addr[i] == P1) first = i;
      if (!mem[req_addr[i][7:2]][14]) clear_cnt = clear_cnt + 1;
    end
    check("periodic list found", 1, first >= 0);
    if (first > 0) begin  // Only a request already in flight may sit inside the window
      check("periodic after in-flight", 1, req_cyc[first - 1] - run_cyc <= PeriodicStart + 1);
    end
    check("periodic request count", first + 3, frame0);
    for (int k = 0; k < 3; k++) check("periodic order", per[k], req_addr[first + k]);
    reg_read(RegServed, served);
    check("skip served count", clear_cnt, served - base);
  endtask

  task automatic test_interrupt();
    logic [31:0] f0, f1, d;
    reg_write(RegStatus, 32'h1);
    reg_write(RegIntEn, 32'h1);
    @(negedge clk);
    check("interrupt idle", 0, intr);
    reg_read(RegFrameNum, f0);
    reg_write(RegControl, 32'h3);
    while (!intr) @(negedge clk);
    reg_read(RegFrameNum, f1);
    check("interrupt frame number", f0 + 1, f1);
    reg_write(RegStatus, 32'h1);
    @(negedge clk);
    check("interrupt cleared", 0, intr);
    reg_write(RegIntEn, 32'h0);
    repeat (FrameLen + 8) begin  // A whole frame with the enable clear
      @(negedge clk);
      check("interrupt masked", 0, intr);
    end
    reg_read(RegStatus, d);
    check("interrupt flag set", 1, d);
    stop_and_settle();
  endtask

  initial begin
    rst_n = 1'b0;
    reg_req = '0;
    dma_rsp = '0;
    for (int i = 0; i < 64; i++) mem[i] = 32'h9e3779b9 * (i + 1);
    put_ed(C1, 1'b0, C2);
    put_ed(C2, 1'b1, 32'h0);
    put_ed(B1, 1'b0, 32'h0);
    put_ed(P1, 1'b0, P2);
    put_ed(P2, 1'b1, P3);
    put_ed(P3, 1'b0, 32'h0);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_registers();
    test_ratio();
    test_periodic_and_skip();
    test_interrupt();
    $display("Regression passed");
    $finish;
  end

endmodule

/* build.f */
src/ohci_pkg.sv
src/ohci_regs.sv
src/ohci_frame_timer.sv
src/ohci_list_service.sv
src/ohci_ed_unpack.sv
src/ohci_host.sv
sim/ohci_host_properties.sv
sim/ohci_host_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the OHCI host testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module ohci_host_tb -Mdir obj_dir -o ohci_sim &&
./obj_dir/ohci_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
